/* logic/fb_pkg.sv */
package fb_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int PIX_W   = 24;       // rgb 8:8:8
    localparam int COORD_W = 16;
    localparam int LEN_W   = 24;
    localparam int IDX_W   = 20;       // linear pixel index inside one region

    typedef logic [PIX_W-1:0]   pixel_t;
    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [LEN_W-1:0]   span_len_t;

    // y * H_DISP + x, no region bit
    typedef logic [IDX_W-1:0]   fb_idx_t;

    // msb picks region 0 or 1, low bits are the pixel index,
    // the lowest log2(BANKS) of those pick the bank
    typedef logic [IDX_W:0]     fb_addr_t;

    // ----------------------------------------------------------
    // buses
    // ----------------------------------------------------------
    // wishbone classic request, master to slave, 48 bits
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        fb_addr_t adr;
        pixel_t   dat;
    } wb_req_t;

    // raster output, 27 bits
    typedef struct packed {
        logic   de;
        logic   hsync;
        logic   vsync;
        pixel_t rgb;
    } video_t;

endpackage

/* logic/span_fill.sv */
module span_fill #(
    parameter int H_DISP = 640,
    parameter int V_DISP = 480,
    parameter int BANKS  = 4
) (
    input  logic              clk,
    input  logic              reset,

    // fill command from the host
    input  logic              enable,     // one pulse starts a span
    input  fb_pkg::coord_t    x_pos,
    input  fb_pkg::coord_t    y_pos,
    input  fb_pkg::pixel_t    pixel,
    input  fb_pkg::span_len_t len,
    input  logic              buf_sel,    // current front region
    output logic              busy,

    // write master, broadcast to all banks
    output fb_pkg::wb_req_t   wb,
    input  logic [BANKS-1:0]  ack         // one bit per bank
);

    localparam int TOTAL = H_DISP * V_DISP;   // pixels per region

    // gap doubles as the setup cycle right after accept
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_WAIT_ACK,
        ST_GAP
    } state_t;

    state_t            state;
    fb_pkg::span_len_t remaining;    // pixels still to write
    fb_pkg::fb_idx_t   idx;          // current pixel index
    fb_pkg::fb_idx_t   start_idx;
    fb_pkg::pixel_t    colour;       // latched fill colour
    logic              region;       // back region, latched at accept
    logic              accept;
    logic              ack_any;
    logic              last_idx;

    assign accept  = enable && (state == ST_IDLE);   // ignored while busy
    assign ack_any = |ack;                           // only the selected bank answers

    assign start_idx = fb_pkg::fb_idx_t'(y_pos * H_DISP + x_pos);
    assign last_idx  = (idx == fb_pkg::fb_idx_t'(TOTAL - 1));

    // ----------------------------------------------------------
    // control fsm
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            remaining <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state     <= ST_GAP;
                        remaining <= len;
                    end
                end
                ST_GAP: begin
                    // len of 0 leaves after this single cycle
                    if (remaining == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_STROBE;
                    end
                end
                ST_STROBE: begin
                    state <= ST_WAIT_ACK;   // bank registers ack now
                end
                ST_WAIT_ACK: begin
                    if (ack_any) begin      // slow ack just stretches busy
                        state     <= ST_GAP;
                        remaining <= fb_pkg::span_len_t'(remaining - 1);
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // address and data
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            idx    <= start_idx;
            colour <= pixel;
            region <= ~buf_sel;         // write the hidden buffer
        end else if (state == ST_WAIT_ACK && ack_any) begin
            if (last_idx) begin
                idx <= '0;              // wrap past the end of the frame
            end else begin
                idx <= fb_pkg::fb_idx_t'(idx + 1);
            end
        end
    end

    // held steady from strobe until ack, dropped in gap
    always_comb begin
        wb.cyc = (state == ST_STROBE) || (state == ST_WAIT_ACK);
        wb.stb = wb.cyc;
        wb.we  = 1'b1;                  // write-only master
        wb.adr = {region, idx};
        wb.dat = colour;
    end

    assign busy = (state != ST_IDLE);

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    // only the addressed bank may answer
    a_one_ack : assert property (
        @(posedge clk) disable iff (reset) $onehot0(ack)
    );

    // a bank may only answer a strobe seen on the previous cycle
    a_ack_after_stb : assert property (
        @(posedge clk) disable iff (reset) ack_any |-> $past(wb.stb)
    );

endmodule

/* logic/fb_bank.sv */
module fb_bank #(
    parameter int BANK_ID = 0,
    parameter int BANKS   = 4,
    parameter int H_DISP  = 640,
    parameter int V_DISP  = 480
) (
    input  logic             clk,
    input  logic             reset,

    // write side, wishbone classic slave
    input  fb_pkg::wb_req_t  wb,
    output logic             ack,

    // read side for scanout
    input  fb_pkg::fb_addr_t rd_addr,
    output fb_pkg::pixel_t   rd_data
);

    localparam int TOTAL  = H_DISP * V_DISP;   // pixels per region
    localparam int WORDS  = TOTAL / BANKS;     // this bank's share of one region
    localparam int WORD_W = $clog2(2 * WORDS);

    fb_pkg::pixel_t    mem [2 * WORDS];       // region 0 then region 1
    logic              sel;
    logic              wr_hit;
    logic [WORD_W-1:0] wr_word;
    logic [WORD_W-1:0] rd_word;

    // region offset plus pixel index divided by the bank count
    function automatic logic [WORD_W-1:0] word_of(fb_pkg::fb_addr_t a);
        int unsigned w;
        w = a[fb_pkg::IDX_W] ? WORDS : 0;
        w = w + int'(a[fb_pkg::IDX_W-1:0]) / BANKS;
        return w[WORD_W-1:0];
    endfunction

    // ----------------------------------------------------------
    // write port
    // ----------------------------------------------------------
    assign sel     = (int'(wb.adr[fb_pkg::IDX_W-1:0]) % BANKS) == BANK_ID;
    assign wr_hit  = wb.cyc && wb.stb && sel && !ack;   // no second ack on held stb
    assign wr_word = word_of(wb.adr);
    assign rd_word = word_of(rd_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= wr_hit;              // one cycle after strobe
        end
    end

    // power-up contents are black
    initial begin
        for (int i = 0; i < 2 * WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit && wb.we) begin
            mem[wr_word] <= wb.dat;     // same edge as ack
        end
    end

    // ----------------------------------------------------------
    // read port
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_word];        // valid one cycle after rd_addr
    end

    // the master holds its request through the ack cycle
    a_req_held : assert property (
        @(posedge clk) disable iff (reset)
            wr_hit |=> (wb.cyc && wb.stb && $stable(wb.adr) && $stable(wb.dat))
    );

    // the fill engine must wrap before it runs off the frame
    a_wr_in_range : assert property (
        @(posedge clk) disable iff (reset)
            wr_hit |-> (int'(wb.adr[fb_pkg::IDX_W-1:0]) < TOTAL)
    );

endmodule

/* logic/scan_out.sv */
module scan_out #(
    parameter int H_DISP  = 640,
    parameter int V_DISP  = 480,
    parameter int H_BLANK = 160,
    parameter int V_BLANK = 45,
    parameter int BANKS   = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             buf_sel,          // front region request

    // read bus to the bank array
    output fb_pkg::fb_addr_t rd_addr,
    input  fb_pkg::pixel_t   rd_data [BANKS],  // one pixel per bank, 1 cycle late

    output fb_pkg::video_t   video
);

    localparam int H_TOTAL = H_DISP + H_BLANK;
    localparam int V_TOTAL = V_DISP + V_BLANK;
    localparam int HS_END  = H_DISP + H_BLANK / 2;       // first half of h blank
    localparam int SEL_W   = (BANKS > 1) ? $clog2(BANKS) : 1;

    fb_pkg::coord_t  h_cnt;
    fb_pkg::coord_t  v_cnt;
    logic            h_end;
    logic            v_end;
    logic            frame_start;

    logic            front_q;          // region held for the frame
    logic            front;            // region used this cycle

    logic            de_now;
    logic            hs_now;
    logic            vs_now;
    fb_pkg::fb_idx_t pix_idx;
    logic [SEL_W-1:0] bank_now;

    // aligned with the returned read data
    logic            de_q;
    logic            hs_q;
    logic            vs_q;
    logic [SEL_W-1:0] bank_q;

    // ----------------------------------------------------------
    // raster counters
    // ----------------------------------------------------------
    assign h_end       = (h_cnt == fb_pkg::coord_t'(H_TOTAL - 1));
    assign v_end       = (v_cnt == fb_pkg::coord_t'(V_TOTAL - 1));
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_end) begin
            h_cnt <= '0;
            if (v_end) begin
                v_cnt <= '0;               // next frame
            end else begin
                v_cnt <= fb_pkg::coord_t'(v_cnt + 1);
            end
        end else begin
            h_cnt <= fb_pkg::coord_t'(h_cnt + 1);
        end
    end

    // ----------------------------------------------------------
    // front buffer select
    // ----------------------------------------------------------
    // buf_sel counts from the first pixel of the frame on
    assign front = frame_start ? buf_sel : front_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            front_q <= 1'b0;
        end else begin
            front_q <= front;
        end
    end

    // ----------------------------------------------------------
    // read addressing and timing
    // ----------------------------------------------------------
    assign de_now = (h_cnt < fb_pkg::coord_t'(H_DISP)) && (v_cnt < fb_pkg::coord_t'(V_DISP));
    assign hs_now = (h_cnt >= fb_pkg::coord_t'(H_DISP)) && (h_cnt < fb_pkg::coord_t'(HS_END));
    assign vs_now = (v_cnt == fb_pkg::coord_t'(V_DISP));    // first blank line only

    // park on pixel 0 outside the active area
    assign pix_idx  = de_now ? fb_pkg::fb_idx_t'(v_cnt * H_DISP + h_cnt) : '0;
    assign bank_now = SEL_W'(int'(pix_idx) % BANKS);     // low index bits
    assign rd_addr  = {front, pix_idx};

    always_ff @(posedge clk) begin
        if (reset) begin
            de_q <= 1'b0;
            hs_q <= 1'b0;
            vs_q <= 1'b0;
        end else begin
            de_q <= de_now;
            hs_q <= hs_now;
            vs_q <= vs_now;
        end
    end

    always_ff @(posedge clk) begin
        bank_q <= bank_now;             // which bank answers next cycle
    end

    // ----------------------------------------------------------
    // video out
    // ----------------------------------------------------------
    always_comb begin
        video.de    = de_q;
        video.hsync = hs_q;
        video.vsync = vs_q;
        video.rgb   = de_q ? rd_data[bank_q] : '0;   // black in blanking
    end

endmodule

/* logic/fb_display_top.sv */
module fb_display_top #(
    parameter int H_DISP  = 640,
    parameter int V_DISP  = 480,
    parameter int H_BLANK = 160,
    parameter int V_BLANK = 45,
    parameter int BANKS   = 4      // power of two
) (
    input  logic              clk,
    input  logic              reset,

    // fill command
    input  logic              enable,
    input  fb_pkg::coord_t    x_pos,
    input  fb_pkg::coord_t    y_pos,
    input  fb_pkg::pixel_t    pixel,
    input  fb_pkg::span_len_t len,
    input  logic              buf_sel,    // front region, taken at frame start
    output logic              busy,

    output fb_pkg::video_t    video
);

    fb_pkg::wb_req_t  wb;                 // broadcast write request
    logic [BANKS-1:0] ack;
    fb_pkg::fb_addr_t rd_addr;            // broadcast read address
    fb_pkg::pixel_t   rd_data [BANKS];

    // ----------------------------------------------------------
    // fill engine
    // ----------------------------------------------------------
    span_fill #(
        .H_DISP (H_DISP),
        .V_DISP (V_DISP),
        .BANKS  (BANKS)
    ) u_span_fill (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .x_pos   (x_pos),
        .y_pos   (y_pos),
        .pixel   (pixel),
        .len     (len),
        .buf_sel (buf_sel),
        .busy    (busy),
        .wb      (wb),
        .ack     (ack)
    );

    // ----------------------------------------------------------
    // interleaved banks
    // ----------------------------------------------------------
    for (genvar i = 0; i < BANKS; i++) begin : g_bank
        fb_bank #(
            .BANK_ID (i),
            .BANKS   (BANKS),
            .H_DISP  (H_DISP),
            .V_DISP  (V_DISP)
        ) u_bank (
            .clk     (clk),
            .reset   (reset),
            .wb      (wb),
            .ack     (ack[i]),
            .rd_addr (rd_addr),
            .rd_data (rd_data[i])
        );
    end

    // scanout drains the front region
    scan_out #(
        .H_DISP  (H_DISP),
        .V_DISP  (V_DISP),
        .H_BLANK (H_BLANK),
        .V_BLANK (V_BLANK),
        .BANKS   (BANKS)
    ) u_scan_out (
        .clk     (clk),
        .reset   (reset),
        .buf_sel (buf_sel),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .video   (video)
    );

endmodule

/* tests/fb_checker.sv */
module fb_checker #(
    parameter int H_DISP  = 16,
    parameter int V_DISP  = 8,
    parameter int H_BLANK = 4,
    parameter int V_BLANK = 2
) (
    input  logic              clk, reset, enable, busy, buf_sel,
    input  fb_pkg::coord_t    x_pos, y_pos,
    input  fb_pkg::pixel_t    pixel,
    input  fb_pkg::span_len_t len,
    input  fb_pkg::video_t    video,
    output int                errors
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TOTAL   = H_DISP * V_DISP;
    localparam int H_TOTAL = H_DISP + H_BLANK;
    localparam int V_TOTAL = V_DISP + V_BLANK;

    fb_pkg::pixel_t model [2][TOTAL];     // both regions
    fb_pkg::video_t expect_q;             // what the next cycle must show
    logic           expect_ok = 1'b0;
    logic           front_q;
    int             h, v;                 // own raster position
    int             exp_h, exp_v;
    int             err_count = 0;
    logic           busy_track;
    int             busy_cycles, busy_expect;

    assign errors = err_count;

    always @(posedge clk) begin
        logic front;
        int   p;
        // ------------------------------------------------------
        // compare last prediction against the video port
        // ------------------------------------------------------
        if (expect_ok && video !== expect_q) begin
            err_count++;
            $write("mismatch at %0t: (%0d,%0d) expected de%b hs%b vs%b rgb %06h, ",
                   $time, exp_h, exp_v, expect_q.de, expect_q.hsync, expect_q.vsync,
                   expect_q.rgb);
            $display("got de%b hs%b vs%b rgb %06h",
                     video.de, video.hsync, video.vsync, video.rgb);
        end
        if (reset) begin
            if (expect_ok && busy) begin
                err_count++;
                $display("busy is high during reset at %0t", $time);
            end
            for (int i = 0; i < TOTAL; i++) begin
                model[0][i] = '0;                      // banks power up black
                model[1][i] = '0;
            end
            h          = 0;
            v          = 0;
            front_q    = 1'b0;
            busy_track = 1'b0;
            expect_q   = '0;                           // all outputs low in reset
            expect_ok  = 1'b1;
        end else begin
            // front region taken on the first cycle of a frame
            front    = (h == 0 && v == 0) ? buf_sel : front_q;
            front_q  = front;
            exp_h    = h;
            exp_v    = v;
            expect_q.de    = (h < H_DISP) && (v < V_DISP);
            expect_q.hsync = (h >= H_DISP) && (h < H_DISP + H_BLANK / 2);
            expect_q.vsync = (v == V_DISP);
            expect_q.rgb   = expect_q.de ? model[front][v * H_DISP + h] : '0;
            if (h == H_TOTAL - 1) begin
                h = 0;
                v = (v == V_TOTAL - 1) ? 0 : v + 1;
            end else begin
                h++;
            end
            // ------------------------------------------------------
            // fill commands and busy length
            // ------------------------------------------------------
            if (busy_track) begin
                if (busy) begin
                    busy_cycles++;
                end else begin
                    busy_track = 1'b0;
                    if (busy_cycles != busy_expect) begin
                        err_count++;
                        $display("mismatch at %0t: busy lasted %0d cycles, expected %0d",
                                 $time, busy_cycles, busy_expect);
                    end
                end
            end
            if (enable && !busy) begin                 // enable while busy is dropped
                p = (int'(y_pos) * H_DISP + int'(x_pos)) % TOTAL;
                for (int i = 0; i < int'(len); i++) begin
                    model[~buf_sel][p] = pixel;        // hidden region
                    p = (p + 1) % TOTAL;               // wraps at frame end
                end
                busy_track  = 1'b1;
                busy_cycles = 0;
                busy_expect = 3 * int'(len) + 1;
            end
        end
    end

endmodule

/* tests/tb_fb_display.sv */
module tb_fb_display;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_DISP   = 16;
    localparam int V_DISP   = 8;
    localparam int H_BLANK  = 4;
    localparam int V_BLANK  = 2;
    localparam int BANKS    = 4;
    localparam int TOTAL    = H_DISP * V_DISP;
    localparam int FRAME    = (H_DISP + H_BLANK) * (V_DISP + V_BLANK);   // cycles
    localparam int MAX_LEN  = TOTAL;
    localparam int RAND_LEN = 40;
    localparam int N_FIXED  = 7;
    localparam int N_RANDOM = 12;
    localparam int MARGIN   = 2 * FRAME + 20;         // frame sync wait plus nudge
    localparam int LIMIT    = (N_FIXED + N_RANDOM + 1) * (2 * FRAME + 3 * MAX_LEN + MARGIN);

    typedef struct packed {
        fb_pkg::coord_t    x;
        fb_pkg::coord_t    y;
        fb_pkg::span_len_t len;
        fb_pkg::pixel_t    pixel;
        logic              buf_sel;     // front region while the span is written
        logic              flip;        // show the span afterwards
        logic              nudge;       // extra enable while busy
    } entry_t;

    logic              clk, reset, enable, buf_sel, busy;
    fb_pkg::coord_t    x_pos, y_pos;
    fb_pkg::pixel_t    pixel;
    fb_pkg::span_len_t len;
    fb_pkg::video_t    video;
    int                errors;
    entry_t            tbl[$];
    string             names[$];
    int                seed   = 32'h7be6;
    int                n_pass = 0;
    int                n_fail = 0;

    fb_display_top #(.H_DISP(H_DISP), .V_DISP(V_DISP), .H_BLANK(H_BLANK),
                     .V_BLANK(V_BLANK), .BANKS(BANKS)) u_fb_display_top (
        .clk(clk), .reset(reset), .enable(enable), .x_pos(x_pos), .y_pos(y_pos),
        .pixel(pixel), .len(len), .buf_sel(buf_sel), .busy(busy), .video(video)
    );

    fb_checker #(.H_DISP(H_DISP), .V_DISP(V_DISP), .H_BLANK(H_BLANK),
                 .V_BLANK(V_BLANK)) u_checker (
        .clk(clk), .reset(reset), .enable(enable), .busy(busy), .buf_sel(buf_sel),
        .x_pos(x_pos), .y_pos(y_pos), .pixel(pixel), .len(len), .video(video),
        .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_entry(input string name, input int x, y, n,
                             input fb_pkg::pixel_t colour, input logic sel, flip, nudge);
        entry_t e;
        e.x       = fb_pkg::coord_t'(x);
        e.y       = fb_pkg::coord_t'(y);
        e.len     = fb_pkg::span_len_t'(n);
        e.pixel   = colour;
        e.buf_sel = sel;
        e.flip    = flip;
        e.nudge   = nudge;
        tbl.push_back(e);
        names.push_back(name);
    endtask

    // vsync marks the end of a frame, the first de after it opens the next one
    task automatic wait_frame_start();
        @(posedge clk);
        #1;
        while (!video.vsync) begin
            @(posedge clk);
            #1;
        end
        while (!video.de) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: FAIL with %0d mismatches", name, errors - err_before);
        end
    endtask

    task automatic run_entry(input entry_t e, input string name);
        int err_before;
        err_before = errors;
        buf_sel    = e.buf_sel;
        wait_frame_start();                     // back region now known
        x_pos  = e.x;
        y_pos  = e.y;
        pixel  = e.pixel;
        len    = e.len;
        enable = 1'b1;
        @(posedge clk);
        #1;
        enable = 1'b0;
        if (e.nudge) begin                      // second command while busy
            x_pos  = '0;
            pixel  = ~e.pixel;
            enable = 1'b1;
            @(posedge clk);
            #1;
            enable = 1'b0;
        end
        while (busy) begin
            @(posedge clk);
            #1;
        end
        if (e.flip) begin
            buf_sel = ~buf_sel;
        end
        repeat (2 * FRAME) @(posedge clk);      // two frames for the checker
        #1;
        report_test(name, err_before);
    endtask

    initial begin
        int err_before;
        int x, y, n, r;
        fb_pkg::pixel_t colour;
        reset   = 1'b1;
        enable  = 1'b0;
        x_pos   = '0;
        y_pos   = '0;
        pixel   = '0;
        len     = '0;
        buf_sel = 1'b0;
        // name, x, y, len, colour, front, flip, nudge
        add_entry("short_span",   3, 2, 5,     24'hff0000, 1'b0, 1'b1, 1'b0);
        add_entry("hidden_write", 0, 4, 9,     24'h00ff00, 1'b1, 1'b0, 1'b0);
        add_entry("wrap_frame",  10, 7, 12,    24'h0000ff, 1'b1, 1'b1, 1'b0);
        add_entry("line_cross",  14, 1, 20,    24'h123456, 1'b0, 1'b1, 1'b0);
        add_entry("busy_nudge",   5, 5, 6,     24'habcdef, 1'b1, 1'b1, 1'b1);
        add_entry("zero_len",     8, 3, 0,     24'hffffff, 1'b0, 1'b1, 1'b0);
        add_entry("full_frame",   0, 0, TOTAL, 24'h5a5a5a, 1'b1, 1'b1, 1'b0);
        for (int i = 0; i < N_RANDOM; i++) begin
            x      = int'($unsigned($random(seed)) % H_DISP);
            y      = int'($unsigned($random(seed)) % V_DISP);
            n      = int'($unsigned($random(seed)) % (RAND_LEN + 1));
            colour = fb_pkg::pixel_t'($random(seed));
            r      = $random(seed);
            add_entry($sformatf("random_%0d", i), x, y, n, colour, r[0], r[1], 1'b0);
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        // first frame out of reset is black with quiet syncs
        err_before = errors;
        repeat (FRAME + 2) @(posedge clk);
        #1;
        report_test("reset_state", err_before);
        foreach (tbl[i]) begin
            run_entry(tbl[i], names[i]);
        end
        $display("tests: %0d passed, %0d failed, %0d mismatches", n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout: run still going after %0d cycles", LIMIT);
        $display("Regression failed");
        $finish;
    end

endmodule

/* src.f */
logic/fb_pkg.sv
logic/span_fill.sv
logic/fb_bank.sv
logic/scan_out.sv
logic/fb_display_top.sv
tests/fb_checker.sv
tests/tb_fb_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fb_display \
    -f src.f -o tb_fb_display > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_fb_display > sim.log 2>&1 ; cat sim.log

grep -q "^Regression passed$" sim.log && exit 0 || exit 1
